// File: verilog/riscv_defs.svh
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// major opcodes, instr[6:0]
`define OP_R      7'b0110011 // add, sub, sll ...
`define OP_I      7'b0010011 // addi, slli ...
`define OP_LOAD   7'b0000011 // lw only
`define OP_STORE  7'b0100011 // sw only
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111

`define RESET_PC  32'h0000_0000 // first fetch address
`define NUM_REGS  32            // x0..x31

`endif

// File: verilog/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    typedef logic [31:0] word_t;      // data or address
    typedef logic [6:0]  opcode_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  aluOp_t;     // instruction class for alu decode
    typedef logic [2:0]  immSrc_t;
    typedef logic [1:0]  resultSrc_t;

    // alu class codes from the main decoder
    localparam aluOp_t AOP_R     = 3'b000;
    localparam aluOp_t AOP_I     = 3'b001;
    localparam aluOp_t AOP_LOAD  = 3'b010;
    localparam aluOp_t AOP_STORE = 3'b011;
    localparam aluOp_t AOP_BR    = 3'b100;
    localparam aluOp_t AOP_JUMP  = 3'b101; // jal and jalr share it
    localparam aluOp_t AOP_LUI   = 3'b110;
    localparam aluOp_t AOP_AUIPC = 3'b111;

    localparam immSrc_t IMM_I = 3'd0;
    localparam immSrc_t IMM_S = 3'd1;
    localparam immSrc_t IMM_B = 3'd2;
    localparam immSrc_t IMM_U = 3'd3;
    localparam immSrc_t IMM_J = 3'd4;

    localparam resultSrc_t RES_ALU   = 2'd0;
    localparam resultSrc_t RES_MEM   = 2'd1;
    localparam resultSrc_t RES_PC4   = 2'd2; // link value
    localparam resultSrc_t RES_PCIMM = 2'd3; // auipc

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10  // lui
    } aluCtrl_e;

    typedef struct packed {
        logic [1:0] pcSrc;     // 01 = redirect
        resultSrc_t resultSrc;
        logic       memWrite;
        logic       aluSrc;    // 1 = imm on alu b
        immSrc_t    immSrc;
        logic       regWrite;
        logic       jalr;      // redirect target from alu
        aluOp_t     aluOp;
    } ctrlSignals_t;

endpackage

`default_nettype wire

// File: verilog/ControlUnit.sv
`timescale 1ns/100ps
`include "riscv_defs.svh"
`default_nettype none

module ControlUnit (
    input  riscv_pkg::opcode_t      opcode, // instr[6:0]
    input  logic                    branch, // condition from BranchUnit
    output riscv_pkg::ctrlSignals_t ctrl
);

    always_comb begin
        // alu class
        case (opcode)
            `OP_R:      ctrl.aluOp = riscv_pkg::AOP_R;
            `OP_I:      ctrl.aluOp = riscv_pkg::AOP_I;
            `OP_LOAD:   ctrl.aluOp = riscv_pkg::AOP_LOAD;
            `OP_STORE:  ctrl.aluOp = riscv_pkg::AOP_STORE;
            `OP_BRANCH: ctrl.aluOp = riscv_pkg::AOP_BR;
            `OP_JAL:    ctrl.aluOp = riscv_pkg::AOP_JUMP;
            `OP_JALR:   ctrl.aluOp = riscv_pkg::AOP_JUMP; // rs1+imm via add
            `OP_LUI:    ctrl.aluOp = riscv_pkg::AOP_LUI;
            `OP_AUIPC:  ctrl.aluOp = riscv_pkg::AOP_AUIPC;
            default:    ctrl.aluOp = riscv_pkg::AOP_R;
        endcase

        case (opcode)
            `OP_JALR: ctrl.jalr = 1'b1;
            default:  ctrl.jalr = 1'b0;
        endcase

        // writeback select
        case (opcode)
            `OP_LOAD:  ctrl.resultSrc = riscv_pkg::RES_MEM;
            `OP_JAL:   ctrl.resultSrc = riscv_pkg::RES_PC4;
            `OP_JALR:  ctrl.resultSrc = riscv_pkg::RES_PC4;
            `OP_AUIPC: ctrl.resultSrc = riscv_pkg::RES_PCIMM;
            default:   ctrl.resultSrc = riscv_pkg::RES_ALU; // r, i, lui
        endcase

        case (opcode)
            `OP_STORE: ctrl.memWrite = 1'b1;
            default:   ctrl.memWrite = 1'b0;
        endcase

        // b operand, rs2 for r-type and branch compare
        case (opcode)
            `OP_I:     ctrl.aluSrc = 1'b1;
            `OP_LOAD:  ctrl.aluSrc = 1'b1;
            `OP_STORE: ctrl.aluSrc = 1'b1;
            `OP_JAL:   ctrl.aluSrc = 1'b1;
            `OP_JALR:  ctrl.aluSrc = 1'b1;
            `OP_LUI:   ctrl.aluSrc = 1'b1;
            `OP_AUIPC: ctrl.aluSrc = 1'b1;
            default:   ctrl.aluSrc = 1'b0;
        endcase

        case (opcode)
            `OP_STORE:  ctrl.immSrc = riscv_pkg::IMM_S;
            `OP_BRANCH: ctrl.immSrc = riscv_pkg::IMM_B;
            `OP_LUI:    ctrl.immSrc = riscv_pkg::IMM_U;
            `OP_AUIPC:  ctrl.immSrc = riscv_pkg::IMM_U;
            `OP_JAL:    ctrl.immSrc = riscv_pkg::IMM_J;
            default:    ctrl.immSrc = riscv_pkg::IMM_I; // i, load, jalr
        endcase

        case (opcode)
            `OP_R:     ctrl.regWrite = 1'b1;
            `OP_I:     ctrl.regWrite = 1'b1;
            `OP_LOAD:  ctrl.regWrite = 1'b1;
            `OP_JAL:   ctrl.regWrite = 1'b1; // link
            `OP_JALR:  ctrl.regWrite = 1'b1;
            `OP_LUI:   ctrl.regWrite = 1'b1;
            `OP_AUIPC: ctrl.regWrite = 1'b1;
            default:   ctrl.regWrite = 1'b0; // store, branch, unknown
        endcase

        // next pc, branch only redirects when taken
        case (opcode)
            `OP_BRANCH: ctrl.pcSrc = branch ? 2'b01 : 2'b00;
            `OP_JAL:    ctrl.pcSrc = 2'b01;
            `OP_JALR:   ctrl.pcSrc = 2'b01;
            default:    ctrl.pcSrc = 2'b00;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/AluDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module AluDecoder (
    input  riscv_pkg::aluOp_t   aluOp,
    input  riscv_pkg::funct3_t  funct3,
    input  logic                funct7b5, // instr[30]
    output riscv_pkg::aluCtrl_e aluCtrl
);

    logic isRType; // sub only exists in r-type

    assign isRType = (aluOp == riscv_pkg::AOP_R);

    always_comb begin
        case (aluOp)
            riscv_pkg::AOP_R,
            riscv_pkg::AOP_I: begin
                case (funct3)
                    3'b000:  aluCtrl = (isRType && funct7b5) ? riscv_pkg::ALU_SUB
                                                             : riscv_pkg::ALU_ADD;
                    3'b001:  aluCtrl = riscv_pkg::ALU_SLL;
                    3'b010:  aluCtrl = riscv_pkg::ALU_SLT;
                    3'b011:  aluCtrl = riscv_pkg::ALU_SLTU;
                    3'b100:  aluCtrl = riscv_pkg::ALU_XOR;
                    3'b101:  aluCtrl = funct7b5 ? riscv_pkg::ALU_SRA // srai too
                                                : riscv_pkg::ALU_SRL;
                    3'b110:  aluCtrl = riscv_pkg::ALU_OR;
                    default: aluCtrl = riscv_pkg::ALU_AND;
                endcase
            end
            riscv_pkg::AOP_BR:  aluCtrl = riscv_pkg::ALU_SUB;   // compare, result unused
            riscv_pkg::AOP_LUI: aluCtrl = riscv_pkg::ALU_PASSB; // imm straight through
            default:            aluCtrl = riscv_pkg::ALU_ADD;   // ld, st, jumps, auipc
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/BranchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module BranchUnit (
    input  riscv_pkg::funct3_t funct3,
    input  riscv_pkg::word_t   rs1Val,
    input  riscv_pkg::word_t   rs2Val,
    output logic               branch // condition met, opcode not checked here
);

    logic isEq;
    logic isLt;  // signed
    logic isLtu; // unsigned

    assign isEq  = (rs1Val == rs2Val);
    assign isLt  = ($signed(rs1Val) < $signed(rs2Val));
    assign isLtu = (rs1Val < rs2Val);

    always_comb begin
        case (funct3)
            3'b000:  branch = isEq;   // beq
            3'b001:  branch = ~isEq;  // bne
            3'b100:  branch = isLt;   // blt
            3'b101:  branch = ~isLt;  // bge
            3'b110:  branch = isLtu;  // bltu
            3'b111:  branch = ~isLtu; // bgeu
            default: branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ImmGen.sv
`timescale 1ns/100ps
`default_nettype none

module ImmGen (
    input  riscv_pkg::word_t   instr,
    input  riscv_pkg::immSrc_t immSrc,
    output riscv_pkg::word_t   imm
);

    always_comb begin
        case (immSrc)
            riscv_pkg::IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            riscv_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // b and j scatter the offset bits, lsb always zero
            riscv_pkg::IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
            riscv_pkg::IMM_U: imm = {instr[31:12], 12'b0}; // upper 20 bits
            riscv_pkg::IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                     instr[20], instr[30:21], 1'b0};
            default:          imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/Alu.sv
`timescale 1ns/100ps
`default_nettype none

module Alu (
    input  riscv_pkg::word_t    a,
    input  riscv_pkg::word_t    b,
    input  riscv_pkg::aluCtrl_e aluCtrl,
    output riscv_pkg::word_t    result
);

    logic [4:0] shamt; // low bits of b only

    assign shamt = b[4:0];

    always_comb begin
        case (aluCtrl)
            riscv_pkg::ALU_ADD:   result = a + b;
            riscv_pkg::ALU_SUB:   result = a - b;
            riscv_pkg::ALU_SLL:   result = a << shamt;
            riscv_pkg::ALU_SLT:   result = {31'b0, $signed(a) < $signed(b)};
            riscv_pkg::ALU_SLTU:  result = {31'b0, a < b};
            riscv_pkg::ALU_XOR:   result = a ^ b;
            riscv_pkg::ALU_SRL:   result = a >> shamt;
            riscv_pkg::ALU_SRA:   result = $signed(a) >>> shamt; // keeps sign
            riscv_pkg::ALU_OR:    result = a | b;
            riscv_pkg::ALU_AND:   result = a & b;
            riscv_pkg::ALU_PASSB: result = b;
            default:              result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/RegFile.sv
`timescale 1ns/100ps
`include "riscv_defs.svh"
`default_nettype none

module RegFile (
    input  logic                clk,
    input  logic                rstN,
    input  riscv_pkg::regAddr_t rs1,
    input  riscv_pkg::regAddr_t rs2,
    input  riscv_pkg::regAddr_t rd,
    input  riscv_pkg::word_t    rdData,
    input  logic                we,
    output riscv_pkg::word_t    rs1Val,
    output riscv_pkg::word_t    rs2Val
);

    riscv_pkg::word_t regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin // x0 stays zero
            regs[rd] <= rdData;
        end
    end

    // async read, same-cycle write not forwarded
    assign rs1Val = regs[rs1];
    assign rs2Val = regs[rs2];

endmodule

`default_nettype wire

// File: verilog/RiscvCore.sv
`timescale 1ns/100ps
`include "riscv_defs.svh"
`default_nettype none

module RiscvCore (
    input  logic             clk,
    input  logic             rstN,
    output riscv_pkg::word_t instrAddr,
    input  riscv_pkg::word_t instr,
    output riscv_pkg::word_t dataAddr,
    output riscv_pkg::word_t dataWdata,
    output logic             dataWe,
    input  riscv_pkg::word_t dataRdata  // comb read from dataAddr
);

    riscv_pkg::word_t        pc;
    riscv_pkg::word_t        pcNext;
    riscv_pkg::word_t        pcPlus4;
    riscv_pkg::word_t        pcTarget; // branch, jal, auipc
    riscv_pkg::word_t        imm;
    riscv_pkg::word_t        rs1Val;
    riscv_pkg::word_t        rs2Val;
    riscv_pkg::word_t        srcB;
    riscv_pkg::word_t        aluResult;
    riscv_pkg::word_t        result;   // writeback
    riscv_pkg::ctrlSignals_t ctrl;
    riscv_pkg::aluCtrl_e     aluCtrl;
    logic                    branch;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;

    always_comb begin
        case (ctrl.pcSrc)
            2'b01:   pcNext = ctrl.jalr ? {aluResult[31:1], 1'b0} : pcTarget;
            default: pcNext = pcPlus4;
        endcase
    end

    assign srcB = ctrl.aluSrc ? imm : rs2Val;

    always_comb begin
        case (ctrl.resultSrc)
            riscv_pkg::RES_MEM:   result = dataRdata;
            riscv_pkg::RES_PC4:   result = pcPlus4;
            riscv_pkg::RES_PCIMM: result = pcTarget;
            default:              result = aluResult;
        endcase
    end

    ControlUnit i_ControlUnit (.opcode(instr[6:0]), .branch(branch), .ctrl(ctrl));

    AluDecoder i_AluDecoder (
        .aluOp(ctrl.aluOp), .funct3(instr[14:12]), .funct7b5(instr[30]), .aluCtrl(aluCtrl)
    );

    BranchUnit i_BranchUnit (
        .funct3(instr[14:12]), .rs1Val(rs1Val), .rs2Val(rs2Val), .branch(branch)
    );

    ImmGen i_ImmGen (.instr(instr), .immSrc(ctrl.immSrc), .imm(imm));

    Alu i_Alu (.a(rs1Val), .b(srcB), .aluCtrl(aluCtrl), .result(aluResult));

    RegFile i_RegFile (
        .clk(clk), .rstN(rstN),
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
        .rdData(result), .we(ctrl.regWrite),
        .rs1Val(rs1Val), .rs2Val(rs2Val)
    );

    assign instrAddr = pc;
    assign dataAddr  = aluResult;       // rs1 + imm on ld/st
    assign dataWdata = rs2Val;
    assign dataWe    = ctrl.memWrite & rstN; // no stores while in reset

endmodule

`default_nettype wire

// File: tests/RiscvCore_assertions.sv
`timescale 1ns/100ps
`include "riscv_defs.svh"
`default_nettype none

module RiscvCore_assertions (
    input wire logic             clk,
    input wire logic             rstN,
    input wire riscv_pkg::word_t instrAddr,
    input wire riscv_pkg::word_t instr,
    input wire riscv_pkg::word_t dataAddr,
    input wire riscv_pkg::word_t dataWdata,
    input wire logic             dataWe
);

    int failCount = 0;

    storeOnlyWe: assert property (@(posedge clk) disable iff (!rstN)
        dataWe |-> (instr[6:0] == `OP_STORE))
        else begin
            failCount++;
            $error("data write enable without a store opcode");
        end

    alignedFetch: assert property (@(posedge clk) instrAddr[0] == 1'b0)
        else begin
            failCount++;
            $error("odd instruction address");
        end

    knownOutputs: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown({instrAddr, dataAddr, dataWdata, dataWe}))
        else begin
            failCount++;
            $error("core output is X");
        end

endmodule

bind RiscvCore RiscvCore_assertions i_RiscvCoreAssertions (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
    .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe)
);

`default_nettype wire

// File: tests/CoreChecker.sv
`timescale 1ns/100ps
`include "riscv_defs.svh"
`default_nettype none

module CoreChecker (
    input wire logic             clk,
    input wire logic             rstN,
    input wire riscv_pkg::word_t instrAddr,
    input wire riscv_pkg::word_t instr,
    input wire riscv_pkg::word_t dataAddr,
    input wire riscv_pkg::word_t dataWdata,
    input wire logic             dataWe,
    input wire riscv_pkg::word_t dataRdata
);

    riscv_pkg::word_t pcModel;
    riscv_pkg::word_t regModel [`NUM_REGS];
    riscv_pkg::word_t memModel [64];
    int               errorCount;
    int               checkCount;

    initial begin
        pcModel    = `RESET_PC;
        errorCount = 0;
        checkCount = 0;
        for (int i = 0; i < `NUM_REGS; i++) regModel[i] = '0;
        // same fill as the memory the testbench serves
        for (int i = 0; i < 64; i++) begin
            memModel[i] = ((32'h1000 + 32'(i * 4)) * 32'h2545_f491) ^ 32'h6d2b_79f5;
        end
    end

    task automatic compare(input string name, input logic [31:0] expVal,
                           input logic [31:0] gotVal);
        checkCount++;
        if (gotVal !== expVal) begin
            errorCount++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expVal, gotVal);
        end
    endtask

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    always @(negedge clk) begin : execute
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] immU;
        logic [31:0] addr;
        logic [31:0] wb;
        logic        wr;
        logic        taken;
        logic [31:0] pcNew;
        op    = instr[6:0];
        f3    = instr[14:12];
        rd    = instr[11:7];
        a     = regModel[instr[19:15]];
        b     = regModel[instr[24:20]];
        immI  = {{20{instr[31]}}, instr[31:20]};
        immS  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        immJ  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        immU  = {instr[31:12], 12'b0};
        wb    = '0;
        wr    = 1'b1;
        pcNew = pcModel + 4;
        if (!rstN) begin
            compare("instrAddr", `RESET_PC, instrAddr);
            compare("dataWe", 32'd0, {31'b0, dataWe});
        end else begin
            compare("instrAddr", pcModel, instrAddr);
            compare("dataWe", {31'b0, op == `OP_STORE}, {31'b0, dataWe});
            case (op)
                `OP_R:   wb = aluRef(f3, instr[30], a, b);
                `OP_I:   wb = aluRef(f3, (f3 == 3'd5) && instr[30], a, immI);
                `OP_LOAD: begin
                    addr = a + immI;
                    compare("dataAddr", addr, dataAddr);
                    compare("dataRdata", memModel[addr[7:2]], dataRdata); // earlier stores
                    wb = memModel[addr[7:2]];
                end
                `OP_STORE: begin
                    addr = a + immS;
                    wr   = 1'b0;
                    compare("dataAddr", addr, dataAddr);
                    compare("dataWdata", b, dataWdata);
                    memModel[addr[7:2]] = b;
                end
                `OP_BRANCH: begin
                    wr = 1'b0;
                    case (f3)
                        3'b000:  taken = (a == b);
                        3'b001:  taken = (a != b);
                        3'b100:  taken = ($signed(a) < $signed(b));
                        3'b101:  taken = ($signed(a) >= $signed(b));
                        3'b110:  taken = (a < b);
                        default: taken = (a >= b);
                    endcase
                    if (taken) pcNew = pcModel + immB;
                end
                `OP_JAL: begin
                    wb    = pcModel + 4;
                    pcNew = pcModel + immJ;
                end
                `OP_JALR: begin
                    wb    = pcModel + 4;
                    pcNew = (a + immI) & ~32'd1; // rs1 read before the link write
                end
                `OP_LUI:   wb = immU;
                `OP_AUIPC: wb = pcModel + immU;
                default:   wr = 1'b0;
            endcase
            if (wr && (rd != 5'd0)) regModel[rd] = wb;
            pcModel = pcNew;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_RiscvCore.sv
`timescale 1ns/100ps
`include "riscv_defs.svh"
`default_nettype none

module tb_RiscvCore;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_INSTR    = 400; // instructions after reset
    localparam riscv_pkg::word_t NOP = 32'h0000_0013; // addi x0, x0, 0
    // sw x0, 0(x1) held during reset, write enable must stay low
    localparam riscv_pkg::word_t RESET_INSTR = {7'b0, 5'd0, 5'd1, 3'b010, 5'd0, `OP_STORE};

    logic             clk;
    logic             rstN;
    riscv_pkg::word_t instrAddr;
    riscv_pkg::word_t instr;
    riscv_pkg::word_t dataAddr;
    riscv_pkg::word_t dataWdata;
    logic             dataWe;
    riscv_pkg::word_t dataRdata;

    riscv_pkg::word_t dataMem [64]; // window at 0x1000
    logic [31:0]      seed;
    logic             pendingStore; // store rd of a load or jump next
    logic [4:0]       pendingReg;
    int               errorTotal;

    always #(CLK_PERIOD / 2) clk = ~clk;

    RiscvCore i_RiscvCore (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe), .dataRdata(dataRdata)
    );

    CoreChecker i_CoreChecker (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe), .dataRdata(dataRdata)
    );

    // memory served outside the core
    assign dataRdata = dataMem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (dataWe) begin
            dataMem[dataAddr[7:2]] <= dataWdata;
        end
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] nextRandom();
        seed = lcgStep(seed);
        return seed;
    endfunction

    function automatic logic [4:0] pickRd(input logic [31:0] r);
        return (r[4:0] == 5'd1) ? 5'd0 : r[4:0]; // x1 holds the data base
    endfunction

    function riscv_pkg::word_t makeInstr();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] off;
        logic [12:0] bOff;
        logic [20:0] jOff;
        logic [11:0] iImm;
        logic [6:0]  f7;
        riscv_pkg::word_t w;
        r    = nextRandom();
        s    = nextRandom();
        rd   = pickRd(s);
        rs1  = s[9:5];
        rs2  = s[14:10];
        f3   = s[17:15];
        off  = {4'b0, s[23:18], 2'b00}; // word in 64-word window
        bOff = 13'($signed({1'b0, s[28:24]}) - 16) << 2; // -64..60
        jOff = {{8{bOff[12]}}, bOff};
        if (pendingStore) begin
            pendingStore = 1'b0;
            return {off[11:5], pendingReg, 5'd1, 3'b010, off[4:0], `OP_STORE};
        end
        case (r[31:29])
            3'd0: begin
                f7 = ((f3 == 3'd0) || (f3 == 3'd5)) ? {1'b0, s[30], 5'b0} : 7'b0;
                w  = {f7, rs2, rs1, f3, rd, `OP_R};
            end
            3'd1: begin
                iImm = r[11:0];
                if (f3 == 3'd1) iImm = {7'b0, r[4:0]};
                if (f3 == 3'd5) iImm = {1'b0, s[30], 5'b0, r[4:0]};
                w = {iImm, rs1, f3, rd, `OP_I};
            end
            3'd2: begin
                w = {off, 5'd1, 3'b010, rd, `OP_LOAD};
                pendingStore = 1'b1;
                pendingReg   = rd;
            end
            3'd3: w = {off[11:5], rs2, 5'd1, 3'b010, off[4:0], `OP_STORE};
            3'd4: begin
                case (r[2:0] % 6)
                    3'd0:    f3 = 3'b000;
                    3'd1:    f3 = 3'b001;
                    3'd2:    f3 = 3'b100;
                    3'd3:    f3 = 3'b101;
                    3'd4:    f3 = 3'b110;
                    default: f3 = 3'b111;
                endcase
                w = {bOff[12], bOff[10:5], rs2, rs1, f3, bOff[4:1], bOff[11], `OP_BRANCH};
            end
            3'd5: begin
                w = {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, `OP_JAL};
                pendingStore = 1'b1;
                pendingReg   = rd;
            end
            3'd6: begin
                iImm = {{5{r[6]}}, r[6:0]}; // -64..63, odd values too
                w    = {iImm, rs1, 3'b000, rd, `OP_JALR};
                pendingStore = 1'b1;
                pendingReg   = rd;
            end
            default: w = {r[19:0], rd, r[0] ? `OP_LUI : `OP_AUIPC};
        endcase
        return w;
    endfunction

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        instr        = RESET_INSTR;
        seed         = 32'h9286_ed8b;
        pendingStore = 1'b0;
        pendingReg   = 5'd0;
        for (int i = 0; i < 64; i++) begin
            dataMem[i] = ((32'h1000 + 32'(i * 4)) * 32'h2545_f491) ^ 32'h6d2b_79f5;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstN  <= 1'b1;
        instr <= {20'h00001, 5'd1, `OP_LUI}; // x1 = 0x1000, data base
        for (int n = 1; n < NUM_INSTR; n++) begin
            @(posedge clk);
            instr <= makeInstr();
        end
        @(posedge clk); // last instruction checked on the negedge before
        instr <= NOP;
        errorTotal = i_CoreChecker.errorCount + i_RiscvCore.i_RiscvCoreAssertions.failCount;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 i_CoreChecker.checkCount, i_CoreChecker.errorCount,
                 i_RiscvCore.i_RiscvCoreAssertions.failCount);
        if (errorTotal == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized from the instruction count
    initial begin
        #((NUM_INSTR + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("timeout, the instruction stream did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/riscv_pkg.sv
verilog/ControlUnit.sv
verilog/AluDecoder.sv
verilog/BranchUnit.sv
verilog/ImmGen.sv
verilog/Alu.sv
verilog/RegFile.sv
verilog/RiscvCore.sv
tests/RiscvCore_assertions.sv
tests/CoreChecker.sv
tests/tb_RiscvCore.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_RiscvCore -f sim.f -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "build or simulation stopped with an error, see build.log and sim.log"
grep -q "^RESULT: PASS$" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
